// File: src/fft_datapath_macros.svh
`ifndef FFT_DATAPATH_MACROS_SVH
`define FFT_DATAPATH_MACROS_SVH

// samples per row, one multiplier lane each
`define LANES 8
// width of one real or imaginary part
`define PART_W 12
// depth of dmem, fmem and tmem
`define ROWS 16
`define ROW_ADDR_W 4
// twiddle parts are Q1.11
`define TW_FRAC 11
`define MUL_LAT 2

`endif

// File: src/fft_datapath_pkg.sv
`include "fft_datapath_macros.svh"

package fft_datapath_pkg;

  // one real or imaginary part
  typedef logic signed [`PART_W-1:0] part_t;

  // real part in the upper half
  typedef logic [2*`PART_W-1:0] sample_t;

  // lane 0 in the lowest bits
  typedef logic [`LANES*2*`PART_W-1:0] row_t;

  typedef logic [`ROW_ADDR_W-1:0] row_addr_t;

endpackage

// File: src/operand_fetch.sv
`include "fft_datapath_macros.svh"

module operand_fetch
  import fft_datapath_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  // host write port
  input  logic      load_valid,
  input  logic      load_twiddle,
  input  row_addr_t load_addr,
  input  row_t      load_data,
  // multiply request
  input  logic      mul_start,
  input  row_addr_t mul_addr,
  input  row_addr_t mul_dst,
  // dmem readout request
  input  logic      rd_valid,
  input  row_addr_t rd_addr,
  // operands toward the lanes
  output logic      lane_valid,
  output row_t      lane_data,
  output row_t      lane_twiddle,
  output row_addr_t lane_dst,
  output row_t      dm_rd_row
);

  // data samples and twiddle factors
  row_t dmem [`ROWS];
  row_t fmem [`ROWS];

  // host writes, one row per strobe
  always_ff @(posedge clk) begin
    if (load_valid) begin
      if (load_twiddle) begin
        fmem[load_addr] <= load_data;
      end else begin
        dmem[load_addr] <= load_data;
      end
    end
  end

  // both rows come from the same address
  always_ff @(posedge clk) begin
    if (mul_start) begin
      lane_data    <= dmem[mul_addr];
      lane_twiddle <= fmem[mul_addr];
      lane_dst     <= mul_dst;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      lane_valid <= 1'b0;
    end else begin
      lane_valid <= mul_start;
    end
  end

  // dmem side of the readout mux is captured whatever the source select
  always_ff @(posedge clk) begin
    if (rd_valid) begin
      dm_rd_row <= dmem[rd_addr];
    end
  end

endmodule

// File: src/twiddle_mul.sv
`include "fft_datapath_macros.svh"

module twiddle_mul
  import fft_datapath_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  logic    op_valid,
  input  sample_t op_data,
  input  sample_t op_twiddle,
  output logic    prod_valid,
  output sample_t prod
);

  part_t ar;
  part_t ai;
  part_t wr;
  part_t wi;

  // stage one products
  logic signed [2*`PART_W-1:0] pr_rr;
  logic signed [2*`PART_W-1:0] pr_ii;
  logic signed [2*`PART_W-1:0] pr_ri;
  logic signed [2*`PART_W-1:0] pr_ir;
  logic                        valid_s1;

  // two guard bits over the product width
  logic signed [2*`PART_W+1:0] re_sum;
  logic signed [2*`PART_W+1:0] im_sum;
  logic signed [2*`PART_W+1:0] re_shr;
  logic signed [2*`PART_W+1:0] im_shr;
  logic signed [`TW_FRAC:0]    rnd;

  assign ar = op_data[2*`PART_W-1:`PART_W];
  assign ai = op_data[`PART_W-1:0];
  assign wr = op_twiddle[2*`PART_W-1:`PART_W];
  assign wi = op_twiddle[`PART_W-1:0];

  always_ff @(posedge clk) begin
    pr_rr <= ar * wr;
    pr_ii <= ai * wi;
    pr_ri <= ar * wi;
    pr_ir <= ai * wr;
  end

  // half an lsb of the result gives round to nearest
  assign rnd    = $signed({2'b01, {(`TW_FRAC-1){1'b0}}});
  assign re_sum = pr_rr - pr_ii + rnd;
  assign im_sum = pr_ri + pr_ir + rnd;
  assign re_shr = re_sum >>> `TW_FRAC;
  assign im_shr = im_sum >>> `TW_FRAC;

  always_ff @(posedge clk) begin
    prod <= {re_shr[`PART_W-1:0], im_shr[`PART_W-1:0]};
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      valid_s1   <= 1'b0;
      prod_valid <= 1'b0;
    end else begin
      valid_s1   <= op_valid;
      prod_valid <= valid_s1;
    end
  end

endmodule

// File: src/result_store.sv
`include "fft_datapath_macros.svh"

module result_store
  import fft_datapath_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  // lane results
  input  row_addr_t lane_dst,
  input  logic      prod_valid,
  input  row_t      prod_row,
  // readout request
  input  logic      rd_valid,
  input  logic      rd_result,
  input  row_addr_t rd_addr,
  input  row_t      dm_rd_row,
  output logic      mul_done,
  output row_t      rd_data,
  output logic      rd_data_valid
);

  row_t tmem [`ROWS];

  // destination rows, in step with the lane pipeline
  row_addr_t dst_pipe [`MUL_LAT];

  // first readout stage
  row_t tm_rd_row;
  logic rd_sel;
  logic rd_pend;

  always_ff @(posedge clk) begin
    dst_pipe[0] <= lane_dst;
    for (int i = 1; i < `MUL_LAT; i++) begin
      dst_pipe[i] <= dst_pipe[i-1];
    end
  end

  // lane 0 stands for all lanes
  always_ff @(posedge clk) begin
    if (prod_valid) begin
      tmem[dst_pipe[`MUL_LAT-1]] <= prod_row;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_valid) begin
      tm_rd_row <= tmem[rd_addr];
      rd_sel    <= rd_result;
    end
  end

  // rd_sel high picks tmem, low picks dmem
  always_ff @(posedge clk) begin
    if (rd_pend) begin
      rd_data <= rd_sel ? tm_rd_row : dm_rd_row;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      mul_done      <= 1'b0;
      rd_pend       <= 1'b0;
      rd_data_valid <= 1'b0;
    end else begin
      mul_done      <= prod_valid;
      rd_pend       <= rd_valid;
      rd_data_valid <= rd_pend;
    end
  end

endmodule

// File: src/fft_datapath.sv
`include "fft_datapath_macros.svh"

module fft_datapath
  import fft_datapath_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      load_valid,
  input  logic      load_twiddle,
  input  row_addr_t load_addr,
  input  row_t      load_data,
  input  logic      mul_start,
  input  row_addr_t mul_addr,
  input  row_addr_t mul_dst,
  input  logic      rd_valid,
  input  logic      rd_result,
  input  row_addr_t rd_addr,
  output logic      mul_done,
  output row_t      rd_data,
  output logic      rd_data_valid
);

  logic      lane_valid;
  row_t      lane_data;
  row_t      lane_twiddle;
  row_addr_t lane_dst;
  row_t      dm_rd_row;

  // products gathered back into a row
  row_t             prod_row;
  logic [`LANES-1:0] lane_prod_valid;

  operand_fetch u_operand_fetch (
    .clk          (clk),
    .rst          (rst),
    .load_valid   (load_valid),
    .load_twiddle (load_twiddle),
    .load_addr    (load_addr),
    .load_data    (load_data),
    .mul_start    (mul_start),
    .mul_addr     (mul_addr),
    .mul_dst      (mul_dst),
    .rd_valid     (rd_valid),
    .rd_addr      (rd_addr),
    .lane_valid   (lane_valid),
    .lane_data    (lane_data),
    .lane_twiddle (lane_twiddle),
    .lane_dst     (lane_dst),
    .dm_rd_row    (dm_rd_row)
  );

  // one complex multiplier per sample of the row
  for (genvar i = 0; i < `LANES; i++) begin : g_lane
    twiddle_mul u_twiddle_mul (
      .clk        (clk),
      .rst        (rst),
      .op_valid   (lane_valid),
      .op_data    (lane_data[i*2*`PART_W +: 2*`PART_W]),
      .op_twiddle (lane_twiddle[i*2*`PART_W +: 2*`PART_W]),
      .prod_valid (lane_prod_valid[i]),
      .prod       (prod_row[i*2*`PART_W +: 2*`PART_W])
    );
  end

  // lanes run in lockstep, so lane 0 carries the strobe
  result_store u_result_store (
    .clk           (clk),
    .rst           (rst),
    .lane_dst      (lane_dst),
    .prod_valid    (lane_prod_valid[0]),
    .prod_row      (prod_row),
    .rd_valid      (rd_valid),
    .rd_result     (rd_result),
    .rd_addr       (rd_addr),
    .dm_rd_row     (dm_rd_row),
    .mul_done      (mul_done),
    .rd_data       (rd_data),
    .rd_data_valid (rd_data_valid)
  );

endmodule

// File: verif/fft_datapath_asserts.sv
module fft_datapath_asserts
  import fft_datapath_pkg::*;
(
  input logic clk,
  input logic rst,
  input logic mul_start,
  input logic mul_done,
  input logic rd_valid,
  input logic rd_data_valid,
  input row_t rd_data
);

  // strobes quiet while held in reset
  a_reset_quiet: assert property (@(posedge clk) rst |-> (!mul_done && !rd_data_valid))
    else $error("mul_done or rd_data_valid high during reset");

  a_rd_latency: assert property (@(posedge clk) disable iff (rst)
    rd_data_valid == $past(rd_valid, 2))
    else $error("rd_data_valid does not follow rd_valid by 2 cycles");

  // fetch, two lane stages, tmem write
  a_mul_latency: assert property (@(posedge clk) disable iff (rst)
    mul_done == $past(mul_start, 4))
    else $error("mul_done does not follow mul_start by 4 cycles");

  a_rd_known: assert property (@(posedge clk) disable iff (rst)
    rd_data_valid |-> !$isunknown(rd_data))
    else $error("rd_data has unknown bits while rd_data_valid is high");

endmodule

bind fft_datapath fft_datapath_asserts u_asserts (
  .clk           (clk),
  .rst           (rst),
  .mul_start     (mul_start),
  .mul_done      (mul_done),
  .rd_valid      (rd_valid),
  .rd_data_valid (rd_data_valid),
  .rd_data       (rd_data)
);

// File: verif/fft_datapath_tb.sv
`include "fft_datapath_macros.svh"

module fft_datapath_tb
  import fft_datapath_pkg::*;
();

  localparam int mix_ops     = 40;
  // readback, unit twiddle, back to back, memory fill, random mix
  localparam int num_ops     = 16 + 4 + 16 + 48 + mix_ops;
  localparam int mul_lat_top = 4;
  localparam int rd_lat_top  = 2;

  logic      clk;
  logic      rst;
  logic      load_valid;
  logic      load_twiddle;
  row_addr_t load_addr;
  row_t      load_data;
  logic      mul_start;
  row_addr_t mul_addr;
  row_addr_t mul_dst;
  logic      rd_valid;
  logic      rd_result;
  row_addr_t rd_addr;
  logic      mul_done;
  row_t      rd_data;
  logic      rd_data_valid;

  integer seed;
  int     err_count;

  // shadow copies of dmem, fmem and tmem
  row_t dmem_sh [`ROWS];
  row_t fmem_sh [`ROWS];
  row_t tmem_sh [`ROWS];

  fft_datapath DUT (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    repeat (num_ops * 10 + 100) @(posedge clk);
    $display("watchdog expired after %0d cycles", num_ops * 10 + 100);
    $display("Verification failed");
    $fatal(1, "simulation timed out");
  end

  task automatic report_failure(input string what);
    err_count++;
    $display("%s", what);
    $display("Verification failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_row(input string name, input row_t got, input row_t exp);
    if (got !== exp) begin
      report_failure($sformatf("MISMATCH %s: got %h, expected %h", name, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      report_failure($sformatf("MISMATCH %s: got %h, expected %h", name, got, exp));
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      report_failure($sformatf("MISMATCH %s: got %h, expected %h", name, got, exp));
    end
  endtask

  // complex product rounded to nearest and scaled down by the twiddle fraction
  function automatic row_t mul_row_model(input row_t d, input row_t w);
    row_t    r;
    sample_t ds;
    sample_t ws;
    int      ar;
    int      ai;
    int      wr;
    int      wi;
    int      re;
    int      im;
    for (int l = 0; l < `LANES; l++) begin
      ds = d[l*2*`PART_W +: 2*`PART_W];
      ws = w[l*2*`PART_W +: 2*`PART_W];
      ar = part_t'(ds[2*`PART_W-1:`PART_W]);
      ai = part_t'(ds[`PART_W-1:0]);
      wr = part_t'(ws[2*`PART_W-1:`PART_W]);
      wi = part_t'(ws[`PART_W-1:0]);
      re = (ar * wr - ai * wi + 2**(`TW_FRAC-1)) >>> `TW_FRAC;
      im = (ar * wi + ai * wr + 2**(`TW_FRAC-1)) >>> `TW_FRAC;
      r[l*2*`PART_W +: 2*`PART_W] = {re[`PART_W-1:0], im[`PART_W-1:0]};
    end
    return r;
  endfunction

  function automatic row_t rand_row();
    row_t r;
    for (int i = 0; i < $bits(row_t) / 32; i++) begin
      r[i*32 +: 32] = $random(seed);
    end
    return r;
  endfunction

  function automatic row_addr_t rand_addr();
    logic [31:0] v;
    v = $random(seed);
    return v[`ROW_ADDR_W-1:0];
  endfunction

  task automatic load_row(input logic twiddle, input row_addr_t addr, input row_t data);
    @(negedge clk);
    load_valid   = 1'b1;
    load_twiddle = twiddle;
    load_addr    = addr;
    load_data    = data;
    @(negedge clk);
    load_valid = 1'b0;
    if (twiddle) begin
      fmem_sh[addr] = data;
    end else begin
      dmem_sh[addr] = data;
    end
  endtask

  task automatic run_multiply(input row_addr_t src, input row_addr_t dst);
    int cycles;
    @(negedge clk);
    mul_start = 1'b1;
    mul_addr  = src;
    mul_dst   = dst;
    @(negedge clk);
    mul_start = 1'b0;
    cycles    = 1;
    while (mul_done !== 1'b1 && cycles < 10) begin
      @(negedge clk);
      cycles++;
    end
    if (mul_done !== 1'b1) begin
      report_failure("mul_done never arrived after mul_start");
    end
    check_count("mul_done latency", cycles, mul_lat_top);
    tmem_sh[dst] = mul_row_model(dmem_sh[src], fmem_sh[src]);
  endtask

  task automatic read_and_check(input logic src, input row_addr_t addr);
    int cycles;
    @(negedge clk);
    rd_valid  = 1'b1;
    rd_result = src;
    rd_addr   = addr;
    @(negedge clk);
    rd_valid = 1'b0;
    cycles   = 1;
    while (rd_data_valid !== 1'b1 && cycles < 8) begin
      @(negedge clk);
      cycles++;
    end
    if (rd_data_valid !== 1'b1) begin
      report_failure("rd_data_valid never arrived after rd_valid");
    end
    check_count("rd_data_valid latency", cycles, rd_lat_top);
    check_row("rd_data", rd_data, src ? tmem_sh[addr] : dmem_sh[addr]);
  endtask

  task automatic test_idle_after_reset();
    repeat (10) begin
      @(negedge clk);
      check_bit("mul_done", mul_done, 1'b0);
      check_bit("rd_data_valid", rd_data_valid, 1'b0);
    end
  endtask

  task automatic test_dmem_readback();
    for (int i = 0; i < 8; i++) begin
      load_row(1'b0, row_addr_t'(i), rand_row());
    end
    for (int i = 0; i < 8; i++) begin
      read_and_check(1'b0, row_addr_t'(i));
    end
  endtask

  task automatic test_unit_twiddle();
    row_t tw;
    // just under 1.0 real and zero imaginary
    for (int l = 0; l < `LANES; l++) begin
      tw[l*2*`PART_W +: 2*`PART_W] = {12'h7ff, 12'h000};
    end
    load_row(1'b1, 4'd12, tw);
    load_row(1'b0, 4'd12, rand_row());
    run_multiply(4'd12, 4'd13);
    read_and_check(1'b1, 4'd13);
  endtask

  task automatic test_back_to_back();
    row_addr_t src [4];
    row_addr_t dst [4];
    int        done_seen;
    done_seen = 0;
    for (int i = 0; i < 4; i++) begin
      src[i] = row_addr_t'(4 + i);
      dst[i] = row_addr_t'(8 + i);
      load_row(1'b0, src[i], rand_row());
      load_row(1'b1, src[i], rand_row());
    end
    fork
      begin
        for (int i = 0; i < 4; i++) begin
          @(negedge clk);
          mul_start = 1'b1;
          mul_addr  = src[i];
          mul_dst   = dst[i];
        end
        @(negedge clk);
        mul_start = 1'b0;
      end
      begin
        repeat (12) begin
          @(negedge clk);
          if (mul_done === 1'b1) begin
            done_seen++;
          end
        end
      end
    join
    check_count("mul_done pulses", done_seen, 4);
    for (int i = 0; i < 4; i++) begin
      tmem_sh[dst[i]] = mul_row_model(dmem_sh[src[i]], fmem_sh[src[i]]);
      read_and_check(1'b1, dst[i]);
    end
  endtask

  task automatic test_random_mix();
    logic [31:0] pick;
    // every row is written first so no readout meets an empty row
    for (int i = 0; i < `ROWS; i++) begin
      load_row(1'b0, row_addr_t'(i), rand_row());
      load_row(1'b1, row_addr_t'(i), rand_row());
      run_multiply(row_addr_t'(i), row_addr_t'(i));
    end
    for (int n = 0; n < mix_ops; n++) begin
      pick = $random(seed);
      case (pick[1:0])
        2'd0: load_row(1'b1, rand_addr(), rand_row());
        2'd1: load_row(1'b0, rand_addr(), rand_row());
        2'd2: run_multiply(rand_addr(), rand_addr());
        default: read_and_check(pick[2], rand_addr());
      endcase
    end
  endtask

  initial begin
    seed         = 32'h413d;
    err_count    = 0;
    rst          = 1'b1;
    load_valid   = 1'b0;
    load_twiddle = 1'b0;
    load_addr    = '0;
    load_data    = '0;
    mul_start    = 1'b0;
    mul_addr     = '0;
    mul_dst      = '0;
    rd_valid     = 1'b0;
    rd_result    = 1'b0;
    rd_addr      = '0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    test_idle_after_reset();
    test_dmem_readback();
    test_unit_twiddle();
    test_back_to_back();
    test_random_mix();
    if (err_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// File: fft_datapath.f
+incdir+src
src/fft_datapath_pkg.sv
src/operand_fetch.sv
src/twiddle_mul.sv
src/result_store.sv
src/fft_datapath.sv
verif/fft_datapath_asserts.sv
verif/fft_datapath_tb.sv
